//--- verilog.f
hw/tinker_pkg.sv
hw/fetch_unit.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/data_memory.sv
hw/tinker_core.sv
tb/tinker_core_chk.sv
tb/tinker_core_tb.sv

//--- Makefile
# Verilator build and run of the Tinker core testbench

BIN := obj_dir/Vtinker_core_tb

.PHONY: all run clean

all: run

# Rebuilt only when the file list or one of its sources changes
$(BIN): verilog.f $(shell cat verilog.f)
	verilator --binary --timing --assert -j 0 --top-module tinker_core_tb -f verilog.f

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/tinker_core_tb.sv
// Directed testbench for the Tinker core with default parameters
// Programs sit at instruction index 0, where the reset PC 0x2000 points

module tinker_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import tinker_pkg::*;

    localparam int     NUM_TESTS    = 5;
    localparam int     RESET_CYCLES = 4;
    localparam int     MAX_PROG     = 32;  // Program and padding, loaded during reset
    localparam int     CYCLE_LIMIT  = NUM_TESTS * (100 + RESET_CYCLES + MAX_PROG);
    localparam instr_t NOP_WORD     = 32'hF800_0000;  // Unassigned opcode 31

    logic       clk;
    logic       reset;
    logic       imem_we;
    logic [7:0] imem_addr;
    instr_t     imem_data;
    logic       hlt;
    logic       wb_valid;
    retire_t    retire;
    logic       dmem_we;
    addr_t      dmem_addr;

    instr_t  prog [$];
    retire_t exp_ret [$];
    retire_t got_ret [$];
    addr_t   exp_st [$];
    addr_t   got_st [$];
    word_t   model_mem [int];  // Keyed by data word index
    int      cycles = 0;

    tinker_core tinker_core_inst (
        .clk       (clk),
        .reset     (reset),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .hlt       (hlt),
        .wb_valid  (wb_valid),
        .retire    (retire),
        .dmem_we   (dmem_we),
        .dmem_addr (dmem_addr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ########################################################################
    // Failure reporting and timeout
    // ########################################################################
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what);
        report_failure($sformatf("mismatch at time %0t: %s", $time, what));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            report_failure($sformatf("Timeout after %0d cycles, a halt never came", cycles));
        end
    end

    // ########################################################################
    // Program building
    // ########################################################################
    function automatic instr_t encode(input logic [4:0] op, input int rd, input int rs,
                                      input int rt, input int lit);
        return {op, 5'(rd), 5'(rs), 5'(rt), 12'(lit)};
    endfunction

    task automatic emit(input logic [4:0] op, input int rd, input int rs,
                        input int rt, input int lit);
        prog.push_back(encode(op, rd, rs, rt, lit));
    endtask

    function automatic int rand_lit();
        return int'($urandom_range(4095, 0));
    endfunction

    // Sequential ISA model, one instruction at a time until PRIV 0
    task automatic model_program();
        word_t      r [32];
        addr_t      pc;
        addr_t      next_pc;
        addr_t      addr;
        instr_t     ins;
        logic [4:0] op;
        reg_addr_t  rd;
        reg_addr_t  rs;
        reg_addr_t  rt;
        word_t      lit;
        word_t      res;
        logic       wr;
        logic       done;
        retire_t    rec;
        foreach (r[i]) begin
            r[i] = '0;
        end
        pc   = 64'h2000;
        done = 1'b0;
        for (int step = 0; step < 200 && !done; step++) begin
            ins = (int'(pc[9:2]) < prog.size()) ? prog[pc[9:2]] : NOP_WORD;
            {op, rd, rs, rt} = ins[31:12];
            lit     = word_t'(ins[11:0]);
            res     = '0;
            wr      = 1'b1;
            next_pc = pc + 64'd4;
            case (op)
                OP_AND:     res = r[rs] & r[rt];
                OP_OR:      res = r[rs] | r[rt];
                OP_XOR:     res = r[rs] ^ r[rt];
                OP_NOT:     res = ~r[rs];
                OP_SHFTR:   res = r[rs] >> r[rt][5:0];
                OP_SHFTRI:  res = r[rd] >> lit[5:0];
                OP_SHFTL:   res = r[rs] << r[rt][5:0];
                OP_SHFTLI:  res = r[rd] << lit[5:0];
                OP_ADD:     res = r[rs] + r[rt];
                OP_ADDI:    res = r[rd] + lit;
                OP_SUB:     res = r[rs] - r[rt];
                OP_SUBI:    res = r[rd] - lit;
                OP_MOV_REG: res = r[rs];
                OP_MOV_LIT: res = {r[rd][63:12], lit[11:0]};
                OP_MOV_MEM: begin
                    addr = r[rs] + lit;
                    res  = model_mem.exists(int'(addr[10:3])) ? model_mem[int'(addr[10:3])] : '0;
                end
                OP_MOV_STR: begin
                    addr = r[rd] + lit;
                    model_mem[int'(addr[10:3])] = r[rs];
                    exp_st.push_back(addr);
                    wr = 1'b0;
                end
                OP_BR: begin
                    next_pc = r[rd];
                    wr      = 1'b0;
                end
                OP_BRR: begin
                    next_pc = pc + r[rd];
                    wr      = 1'b0;
                end
                OP_BRRI: begin
                    next_pc = pc + lit;
                    wr      = 1'b0;
                end
                OP_BRNZ: begin
                    if (r[rs] != '0) next_pc = r[rd];
                    wr = 1'b0;
                end
                OP_BRGT: begin
                    if ($signed(r[rs]) > $signed(r[rt])) next_pc = r[rd];
                    wr = 1'b0;
                end
                OP_PRIV: begin
                    done = (lit == '0);
                    wr   = 1'b0;
                end
                default: wr = 1'b0;  // Unknown opcodes do nothing
            endcase
            if (wr) begin
                rec.wb_addr = rd;
                rec.wb_data = res;
                exp_ret.push_back(rec);
                r[rd] = res;
            end
            pc = next_pc;
        end
    endtask

    // ########################################################################
    // Load, run and compare
    // ########################################################################
    task automatic run_program(input string name);
        exp_ret.delete();
        exp_st.delete();
        got_ret.delete();
        got_st.delete();
        model_program();
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < prog.size() + 4; i++) begin
            imem_we   = 1'b1;
            imem_addr = 8'(i);
            imem_data = (i < prog.size()) ? prog[i] : NOP_WORD;  // Padding after the end
            @(negedge clk);
        end
        imem_we = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        do begin
            @(negedge clk);
            if (wb_valid) got_ret.push_back(retire);
            if (dmem_we) got_st.push_back(dmem_addr);
        end while (!hlt);
        assert (got_ret.size() == exp_ret.size())
            else report_mismatch($sformatf("%s retired %0d writes, expected %0d",
                                           name, got_ret.size(), exp_ret.size()));
        foreach (exp_ret[i]) begin
            assert (got_ret[i] == exp_ret[i])
                else report_mismatch($sformatf("%s write %0d is r%0d=%h, expected r%0d=%h",
                                               name, i, got_ret[i].wb_addr, got_ret[i].wb_data,
                                               exp_ret[i].wb_addr, exp_ret[i].wb_data));
        end
        assert (got_st.size() == exp_st.size())
            else report_mismatch($sformatf("%s made %0d stores, expected %0d",
                                           name, got_st.size(), exp_st.size()));
        foreach (exp_st[i]) begin
            assert (got_st[i] == exp_st[i])
                else report_mismatch($sformatf("%s store %0d at %h, expected %h",
                                               name, i, got_st[i], exp_st[i]));
        end
        // hlt is a single pulse
        repeat (3) begin
            @(negedge clk);
            assert (!hlt) else report_failure($sformatf("%s: hlt stayed high", name));
        end
        assert (tinker_core_inst.execute_stage_inst.tinker_core_chk_inst.error_count == 0)
            else report_failure($sformatf("%s: a pipeline control assertion failed", name));
        $display("%s: %0d writes and %0d stores checked", name, got_ret.size(), got_st.size());
    endtask

    // ########################################################################
    // Directed tests
    // ########################################################################
    task automatic test_alu();
        prog.delete();
        emit(OP_MOV_LIT, 1, 0, 0, rand_lit());
        emit(OP_MOV_LIT, 2, 0, 0, rand_lit());
        emit(OP_ADD, 3, 1, 2, 0);
        emit(OP_ADDI, 3, 0, 0, rand_lit());
        emit(OP_SUB, 4, 2, 1, 0);               // May wrap below zero
        emit(OP_SUBI, 4, 0, 0, rand_lit());
        emit(OP_AND, 5, 1, 2, 0);
        emit(OP_OR, 6, 1, 2, 0);
        emit(OP_XOR, 7, 1, 2, 0);
        emit(OP_NOT, 8, 1, 0, 0);
        emit(OP_MOV_LIT, 8, 0, 0, rand_lit());  // Upper bits of ~r1 stay
        emit(OP_SHFTR, 9, 4, 2, 0);
        emit(OP_SHFTL, 10, 3, 1, 0);
        emit(OP_SHFTRI, 4, 0, 0, rand_lit() % 64);
        emit(OP_SHFTLI, 3, 0, 0, rand_lit());   // Low 6 bits only
        emit(OP_MOV_REG, 11, 8, 0, 0);
        emit(OP_PRIV, 0, 0, 0, 0);
        run_program("alu");
    endtask

    task automatic test_dependencies();
        prog.delete();
        emit(OP_MOV_LIT, 1, 0, 0, rand_lit());
        emit(OP_ADDI, 1, 0, 0, rand_lit());
        emit(OP_ADD, 2, 1, 1, 0);
        emit(OP_ADD, 3, 2, 1, 0);  // Previous and two before
        emit(OP_SUB, 1, 3, 2, 0);
        emit(OP_XOR, 4, 1, 3, 0);
        emit(OP_SHFTLI, 4, 0, 0, 5);
        emit(OP_SUB, 5, 4, 1, 0);
        emit(OP_NOT, 5, 5, 0, 0);
        emit(OP_SHFTR, 6, 5, 1, 0);
        emit(OP_MOV_REG, 7, 6, 0, 0);
        emit(OP_OR, 7, 7, 5, 0);
        emit(OP_PRIV, 0, 0, 0, 0);
        run_program("dependencies");
    endtask

    task automatic test_memory();
        prog.delete();
        emit(OP_MOV_LIT, 1, 0, 0, 12'h100);  // Base address
        emit(OP_MOV_LIT, 2, 0, 0, rand_lit());
        emit(OP_MOV_STR, 1, 2, 0, 8);
        emit(OP_MOV_MEM, 3, 1, 0, 8);
        emit(OP_ADD, 4, 3, 3, 0);            // Load used at once
        emit(OP_ADDI, 2, 0, 0, rand_lit());
        emit(OP_MOV_STR, 1, 2, 0, 16);
        emit(OP_MOV_LIT, 5, 0, 0, 12'h48);
        emit(OP_MOV_STR, 5, 4, 0, 0);        // Base from the previous result
        emit(OP_MOV_MEM, 6, 1, 0, 16);
        emit(OP_MOV_MEM, 7, 5, 0, 0);
        emit(OP_SUB, 7, 7, 6, 0);
        emit(OP_PRIV, 0, 0, 0, 0);
        run_program("memory");
    endtask

    task automatic test_branches();
        prog.delete();
        emit(OP_MOV_LIT, 1, 0, 0, 1);
        emit(OP_BRRI, 0, 0, 0, 12);          // To index 4
        emit(OP_MOV_LIT, 9, 0, 0, 12'h111);
        emit(OP_MOV_LIT, 9, 0, 0, 12'h222);
        emit(OP_MOV_LIT, 2, 0, 0, 36);
        emit(OP_BRNZ, 2, 1, 0, 0);           // Taken to index 9
        emit(OP_MOV_LIT, 9, 0, 0, 12'h333);
        emit(OP_ADDI, 1, 0, 0, 100);
        emit(OP_MOV_LIT, 9, 0, 0, 12'h444);
        emit(OP_MOV_LIT, 3, 0, 0, 8);
        emit(OP_BRNZ, 3, 0, 0, 0);           // r0 is zero, falls through
        emit(OP_MOV_LIT, 4, 0, 0, 5);
        emit(OP_BRGT, 3, 1, 4, 0);           // 1 > 5 fails
        emit(OP_MOV_LIT, 5, 0, 0, 7);
        emit(OP_MOV_LIT, 6, 0, 0, 76);
        emit(OP_BRGT, 6, 4, 1, 0);           // 5 > 1, taken to index 19
        emit(OP_MOV_LIT, 9, 0, 0, 12'h555);
        emit(OP_MOV_LIT, 9, 0, 0, 12'h666);
        emit(OP_ADDI, 5, 0, 0, 1);
        emit(OP_ADDI, 1, 0, 0, 1);
        emit(OP_PRIV, 0, 0, 0, 0);
        run_program("branches");
    endtask

    task automatic test_halt();
        prog.delete();
        emit(OP_MOV_LIT, 1, 0, 0, rand_lit());
        emit(OP_PRIV, 0, 0, 0, 5);           // Nonzero literal, no halt
        emit(5'd20, 2, 1, 1, 0);             // Unassigned opcode
        emit(OP_ADDI, 1, 0, 0, 3);
        emit(OP_PRIV, 0, 0, 0, 0);
        emit(OP_MOV_LIT, 2, 0, 0, 9);        // Behind the halt
        run_program("halt");
    endtask

    initial begin
        reset     = 1'b1;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = NOP_WORD;
        void'($urandom(32'ha6b2));
        test_alu();
        test_dependencies();
        test_memory();
        test_branches();
        test_halt();
        $display("Verification passed");
        $finish;
    end

endmodule

//--- tb/tinker_core_chk.sv
// Pipeline control checks, bound into the execute stage
// Active only while reset is low

module tinker_core_chk (
    input logic                clk,
    input logic                reset,
    input tinker_pkg::ex_mem_t ex_mem
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned error_count = 0;  // Failed assertions so far

    // ########################################################################
    // EX/MEM control
    // ########################################################################

    // A taken branch in MEM empties EX/MEM at the same edge
    branch_flush: assert property (@(posedge clk) disable iff (reset)
        ex_mem.branch_taken |=> (ex_mem.ctrl == '0))
        else begin
            $error("EX/MEM control bits set in the cycle after a taken branch");
            error_count++;
        end

    halt_no_write: assert property (@(posedge clk) disable iff (reset)
        ex_mem.halt |-> !ex_mem.ctrl.reg_write)
        else begin
            $error("halt in MEM together with a register write");
            error_count++;
        end

    // Load and store never share one instruction
    mem_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ex_mem.ctrl.mem_read && ex_mem.ctrl.mem_write))
        else begin
            $error("mem_read and mem_write set together in EX/MEM");
            error_count++;
        end

endmodule

bind execute_stage tinker_core_chk tinker_core_chk_inst (
    .clk    (clk),
    .reset  (reset),
    .ex_mem (ex_mem)
);

//--- hw/tinker_core.sv
// Four-stage Tinker core, fetch, decode, execute and memory/write-back
// Program is loaded through the imem port while reset is high. No stalls, no MUL/DIV

module tinker_core #(
    parameter tinker_pkg::addr_t RESET_PC   = 64'h2000,
    parameter int                IMEM_WORDS = 256,
    parameter int                DATA_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
    input  tinker_pkg::instr_t            imem_data,
    output logic                          hlt,
    output logic                          wb_valid,
    output tinker_pkg::retire_t           retire,
    output logic                          dmem_we,
    output tinker_pkg::addr_t             dmem_addr
);
    import tinker_pkg::*;

    addr_t     pc_de;
    instr_t    instr_de;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    reg_addr_t rd_addr;
    word_t     rs_data;
    word_t     rt_data;
    word_t     rd_data;
    de_ex_t    de_ex;
    ex_mem_t   ex_mem;
    word_t     wb_data;
    logic      redirect;

    assign redirect = ex_mem.branch_taken;  // Taken branch now in MEM

    fetch_unit #(
        .RESET_PC   (RESET_PC),
        .IMEM_WORDS (IMEM_WORDS)
    ) fetch_unit_inst (
        .clk         (clk),
        .reset       (reset),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .redirect    (redirect),
        .redirect_pc (ex_mem.branch_pc),
        .pc_de       (pc_de),
        .instr_de    (instr_de)
    );

    decode_stage decode_stage_inst (
        .clk      (clk),
        .reset    (reset),
        .flush    (redirect),
        .pc_de    (pc_de),
        .instr_de (instr_de),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .rd_addr  (rd_addr),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .rd_data  (rd_data),
        .de_ex    (de_ex)
    );

    register_file register_file_inst (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (rs_addr),
        .rd_addr_b (rt_addr),
        .rd_addr_c (rd_addr),
        .rd_data_a (rs_data),
        .rd_data_b (rt_data),
        .rd_data_c (rd_data),
        .we        (ex_mem.ctrl.reg_write),
        .wr_addr   (ex_mem.rd),
        .wr_data   (wb_data)
    );

    execute_stage execute_stage_inst (
        .clk     (clk),
        .reset   (reset),
        .flush   (redirect),
        .de_ex   (de_ex),
        .wb_data (wb_data),
        .ex_mem  (ex_mem)
    );

    data_memory #(
        .DATA_WORDS (DATA_WORDS)
    ) data_memory_inst (
        .clk     (clk),
        .ex_mem  (ex_mem),
        .wb_data (wb_data)
    );

    // Visible results, all taken from the MEM stage
    assign hlt       = ex_mem.halt;
    assign wb_valid  = ex_mem.ctrl.reg_write;
    assign retire    = '{wb_addr: ex_mem.rd, wb_data: wb_data};
    assign dmem_we   = ex_mem.ctrl.mem_write;
    assign dmem_addr = ex_mem.mem_addr;

endmodule

//--- hw/data_memory.sv
// Word-addressed data memory and write-back select
// DATA_WORDS must be a power of two. Address bits 2:0 are ignored, so accesses are
// assumed aligned and wrap over the memory

module data_memory #(
    parameter int DATA_WORDS = 256
) (
    input  logic                clk,
    input  tinker_pkg::ex_mem_t ex_mem,
    output tinker_pkg::word_t   wb_data
);
    import tinker_pkg::*;

    localparam int DATA_AW = $clog2(DATA_WORDS);

    word_t              mem [DATA_WORDS];
    logic [DATA_AW-1:0] index;
    word_t              load_data;

    assign index     = ex_mem.mem_addr[DATA_AW+2:3];
    assign load_data = mem[index];  // Combinational read

    // Store lands at the end of the MEM cycle
    always_ff @(posedge clk) begin
        if (ex_mem.ctrl.mem_write) begin
            mem[index] <= ex_mem.mem_wdata;
        end
    end

    // Feeds both the register write port and EX forwarding
    assign wb_data = ex_mem.ctrl.mem_to_reg ? load_data : ex_mem.result;

endmodule

//--- hw/execute_stage.sv
// Execute stage with MEM-to-EX forwarding and the EX/MEM register
// Branches resolve here and redirect fetch one cycle later from MEM

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  tinker_pkg::de_ex_t  de_ex,
    input  tinker_pkg::word_t   wb_data,
    output tinker_pkg::ex_mem_t ex_mem
);
    import tinker_pkg::*;

    logic    fwd_a;
    logic    fwd_b;
    logic    fwd_c;
    word_t   a_val;
    word_t   b_reg;  // rt operand, only meaningful for register forms
    word_t   c_val;
    logic    cond;
    ex_mem_t ex_next;

    // ########################################################################
    // Forwarding from the instruction in MEM
    // ########################################################################
    assign fwd_a = ex_mem.ctrl.reg_write && (ex_mem.rd == de_ex.rs);
    assign fwd_b = ex_mem.ctrl.reg_write && (ex_mem.rd == de_ex.rt);
    assign fwd_c = ex_mem.ctrl.reg_write && (ex_mem.rd == de_ex.rd);

    assign a_val = fwd_a ? wb_data : de_ex.a;
    assign b_reg = fwd_b ? wb_data : de_ex.b;
    assign c_val = fwd_c ? wb_data : de_ex.c;

    // ########################################################################
    // ALU, address and branch target
    // ########################################################################
    always_comb begin
        ex_next           = '0;
        ex_next.rd        = de_ex.rd;
        ex_next.ctrl      = de_ex.ctrl;
        ex_next.branch_pc = de_ex.pc + 64'd4;
        cond              = 1'b0;
        case (de_ex.op)
            OP_ADD:     ex_next.result = a_val + b_reg;
            OP_ADDI:    ex_next.result = a_val + de_ex.b;
            OP_SUB:     ex_next.result = a_val - b_reg;
            OP_SUBI:    ex_next.result = a_val - de_ex.b;
            OP_AND:     ex_next.result = a_val & b_reg;
            OP_OR:      ex_next.result = a_val | b_reg;
            OP_XOR:     ex_next.result = a_val ^ b_reg;
            OP_NOT:     ex_next.result = ~a_val;
            OP_SHFTR:   ex_next.result = a_val >> b_reg[5:0];
            OP_SHFTRI:  ex_next.result = a_val >> de_ex.b[5:0];
            OP_SHFTL:   ex_next.result = a_val << b_reg[5:0];
            OP_SHFTLI:  ex_next.result = a_val << de_ex.b[5:0];
            OP_MOV_REG: ex_next.result = a_val;
            OP_MOV_LIT: ex_next.result = {a_val[63:LIT_BITS], de_ex.b[LIT_BITS-1:0]};
            OP_MOV_MEM: ex_next.mem_addr = a_val + de_ex.b;
            OP_MOV_STR: begin
                ex_next.mem_addr  = c_val + de_ex.b;  // Base in rd
                ex_next.mem_wdata = a_val;
            end
            OP_BR: begin
                ex_next.branch_pc = c_val;
                cond              = 1'b1;
            end
            OP_BRR: begin
                ex_next.branch_pc = de_ex.pc + c_val;
                cond              = 1'b1;
            end
            OP_BRRI: begin
                ex_next.branch_pc = de_ex.pc + de_ex.b;
                cond              = 1'b1;
            end
            OP_BRNZ: begin
                ex_next.branch_pc = c_val;
                cond              = (a_val != '0);
            end
            OP_BRGT: begin
                ex_next.branch_pc = c_val;
                cond              = ($signed(a_val) > $signed(b_reg));
            end
            default: ;
        endcase
        ex_next.branch_taken = de_ex.ctrl.is_branch && cond;
        ex_next.halt         = (de_ex.op == OP_PRIV) && (de_ex.literal == '0);  // PRIV 0 only
    end

    // EX/MEM register, emptied while its own branch redirects fetch
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else if (flush) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_next;
        end
    end

endmodule

//--- hw/decode_stage.sv
// Decode stage with the DE/EX register
// Immediate forms and MOV_LIT take rd as their first source. Literals are zero-extended

module decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  tinker_pkg::addr_t     pc_de,
    input  tinker_pkg::instr_t    instr_de,
    output tinker_pkg::reg_addr_t rs_addr,
    output tinker_pkg::reg_addr_t rt_addr,
    output tinker_pkg::reg_addr_t rd_addr,
    input  tinker_pkg::word_t     rs_data,
    input  tinker_pkg::word_t     rt_data,
    input  tinker_pkg::word_t     rd_data,
    output tinker_pkg::de_ex_t    de_ex
);
    import tinker_pkg::*;

    opcode_t             op;
    logic [LIT_BITS-1:0] literal;
    logic                use_literal;
    ctrl_t               ctrl;
    de_ex_t              de_ex_next;

    // ########################################################################
    // Field extraction
    // ########################################################################
    assign op      = opcode_t'(instr_de[31:27]);
    assign rd_addr = instr_de[26:22];
    assign rt_addr = instr_de[16:12];
    assign literal = instr_de[LIT_BITS-1:0];

    // ########################################################################
    // Control decode
    // ########################################################################
    always_comb begin
        ctrl        = '0;
        use_literal = 1'b0;
        rs_addr     = instr_de[21:17];
        case (op)
            OP_AND, OP_OR, OP_XOR, OP_NOT, OP_SHFTR, OP_SHFTL,
            OP_ADD, OP_SUB, OP_MOV_REG: begin
                ctrl.reg_write = 1'b1;
            end
            OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI, OP_MOV_LIT: begin
                ctrl.reg_write = 1'b1;
                use_literal    = 1'b1;
                rs_addr        = instr_de[26:22];  // Source is rd itself
            end
            OP_MOV_MEM: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                use_literal     = 1'b1;
            end
            OP_MOV_STR: begin
                ctrl.mem_write = 1'b1;
                use_literal    = 1'b1;
            end
            OP_BR, OP_BRR, OP_BRNZ, OP_BRGT: begin
                ctrl.is_branch = 1'b1;
            end
            OP_BRRI: begin
                ctrl.is_branch = 1'b1;
                use_literal    = 1'b1;
            end
            default: ;  // PRIV and unassigned codes write nothing
        endcase
    end

    always_comb begin
        de_ex_next.pc      = pc_de;
        de_ex_next.op      = op;
        de_ex_next.a       = rs_data;
        de_ex_next.b       = use_literal ? word_t'(literal) : rt_data;
        de_ex_next.c       = rd_data;
        de_ex_next.literal = literal;
        de_ex_next.rd      = rd_addr;
        de_ex_next.rs      = rs_addr;
        de_ex_next.rt      = rt_addr;
        de_ex_next.ctrl    = ctrl;
    end

    // DE/EX register, emptied behind a taken branch
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            de_ex <= '0;
        end else if (flush) begin
            de_ex <= '0;
        end else begin
            de_ex <= de_ex_next;
        end
    end

endmodule

//--- hw/register_file.sv
// 32 x 64-bit register file with three combinational read ports
// R0 is an ordinary register. A write in the same cycle shows on the reads

module register_file (
    input  logic                  clk,
    input  logic                  reset,
    input  tinker_pkg::reg_addr_t rd_addr_a,
    input  tinker_pkg::reg_addr_t rd_addr_b,
    input  tinker_pkg::reg_addr_t rd_addr_c,
    output tinker_pkg::word_t     rd_data_a,
    output tinker_pkg::word_t     rd_data_b,
    output tinker_pkg::word_t     rd_data_c,
    input  logic                  we,
    input  tinker_pkg::reg_addr_t wr_addr,
    input  tinker_pkg::word_t     wr_data
);
    import tinker_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Pass-through so decode sees the write from MEM in the same cycle
    assign rd_data_a = (we && (wr_addr == rd_addr_a)) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (we && (wr_addr == rd_addr_b)) ? wr_data : regs[rd_addr_b];
    assign rd_data_c = (we && (wr_addr == rd_addr_c)) ? wr_data : regs[rd_addr_c];

endmodule

//--- hw/fetch_unit.sv
// PC, instruction memory and IF/DE register
// Instruction memory is written from outside, meant only while reset is held. IMEM_WORDS
// must be a power of two, the PC wraps over it

module fetch_unit #(
    parameter tinker_pkg::addr_t RESET_PC   = 64'h2000,
    parameter int                IMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
    input  tinker_pkg::instr_t            imem_data,
    input  logic                          redirect,
    input  tinker_pkg::addr_t             redirect_pc,
    output tinker_pkg::addr_t             pc_de,
    output tinker_pkg::instr_t            instr_de
);
    import tinker_pkg::*;

    localparam int IMEM_AW = $clog2(IMEM_WORDS);
    // Opcode 31 is unassigned and decodes as a no-op. All zeros would be AND r0
    localparam instr_t BUBBLE = 32'hF800_0000;

    instr_t imem [IMEM_WORDS];
    addr_t  pc;
    instr_t instr_if;

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_data;
        end
    end

    assign instr_if = imem[pc[IMEM_AW+1:2]];  // Word index, byte offset dropped

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc       <= RESET_PC;
            pc_de    <= '0;
            instr_de <= BUBBLE;
        end else if (redirect) begin
            pc       <= redirect_pc;  // Taken branch from MEM
            pc_de    <= '0;
            instr_de <= BUBBLE;
        end else begin
            pc       <= pc + 64'd4;
            pc_de    <= pc;
            instr_de <= instr_if;
        end
    end

endmodule

//--- hw/tinker_pkg.sv
// Shared types for the four-stage Tinker core
// Only the integer, move, branch and PRIV opcodes are named. Other codes decode as no-ops

package tinker_pkg;

    // ########################################################################
    // Widths
    // ########################################################################
    typedef logic [63:0] word_t;
    typedef logic [63:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int LIT_BITS = 12;  // Zero-extended literal field

    // Reference numbering of the 5-bit opcode field
    typedef enum logic [4:0] {
        OP_AND     = 5'd0,
        OP_OR      = 5'd1,
        OP_XOR     = 5'd2,
        OP_NOT     = 5'd3,
        OP_SHFTR   = 5'd4,
        OP_SHFTRI  = 5'd5,
        OP_SHFTL   = 5'd6,
        OP_SHFTLI  = 5'd7,
        OP_BR      = 5'd8,
        OP_BRR     = 5'd9,
        OP_BRRI    = 5'd10,
        OP_BRNZ    = 5'd11,
        OP_BRGT    = 5'd14,
        OP_PRIV    = 5'd15,
        OP_MOV_MEM = 5'd16,
        OP_MOV_REG = 5'd17,
        OP_MOV_LIT = 5'd18,
        OP_MOV_STR = 5'd19,
        OP_ADD     = 5'd24,
        OP_ADDI    = 5'd25,
        OP_SUB     = 5'd26,
        OP_SUBI    = 5'd27
    } opcode_t;

    // ########################################################################
    // Pipeline register contents
    // ########################################################################
    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;  // Write back load data instead of ALU result
        logic is_branch;
    } ctrl_t;

    typedef struct packed {
        addr_t               pc;
        opcode_t             op;
        word_t               a;        // rs value
        word_t               b;        // rt value or literal
        word_t               c;        // rd value
        logic [LIT_BITS-1:0] literal;
        reg_addr_t           rd;
        reg_addr_t           rs;
        reg_addr_t           rt;
        ctrl_t               ctrl;
    } de_ex_t;

    typedef struct packed {
        word_t     result;
        addr_t     mem_addr;
        word_t     mem_wdata;
        addr_t     branch_pc;
        reg_addr_t rd;
        ctrl_t     ctrl;
        logic      branch_taken;
        logic      halt;
    } ex_mem_t;

    typedef struct packed {
        reg_addr_t wb_addr;
        word_t     wb_data;
    } retire_t;

endpackage
